/* all.f */
+incdir+tb
source/bp_pkg.sv
source/counter_table.sv
source/history_unit.sv
source/prediction_selector.sv
source/prediction_writer.sv
source/predictor_control.sv
source/branch_predictor.sv
tb/tb_branch_predictor.sv

/* source/bp_pkg.sv */
package bp_pkg;

  typedef enum logic [1:0] {
    SRC_SP  = 2'd0,   // fixed tie-break order is sp, then lhp, then ghp.
    SRC_LHP = 2'd1,
    SRC_GHP = 2'd2
  } pred_src_e;

  localparam int DEF_ADDR_W = 3;
  localparam int DEF_HIST_W = 2;
  localparam int DEF_STAT_W = 5;   // statistics are signed.
  localparam int TREND_W    = 3;   // signed, saturates at +3 and -3.
  localparam int CNT_W      = 2;   // the msb of a pattern counter is its guess.

endpackage

/* source/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor #(
  parameter int ADDR_W      = bp_pkg::DEF_ADDR_W,
  parameter int HIST_W      = bp_pkg::DEF_HIST_W,
  parameter int STAT_W      = bp_pkg::DEF_STAT_W,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              q_valid,
  output logic              q_ready,
  input  logic [ADDR_W-1:0] q_addr,
  output logic              a_valid,
  input  logic              a_ready,
  output logic              a_taken,
  output bp_pkg::pred_src_e a_src,
  input  logic              o_valid,
  output logic              o_ready,
  input  logic              o_taken
);
  import bp_pkg::*;

  logic                      lookup_en;
  logic                      sel_sp_guess;
  logic                      sel_lhp_guess;
  logic                      sel_ghp_guess;
  logic                      sel_taken;
  pred_src_e                 sel_src;
  logic [HIST_W-1:0]         lhp_index;
  logic [ADDR_W-1:0]         ghp_index;
  logic                      upd_en;
  logic [ADDR_W-1:0]         upd_addr;
  logic                      upd_sp_guess;
  logic                      upd_lhp_guess;
  logic                      upd_ghp_guess;
  logic [HIST_W-1:0]         upd_lhp_index;
  logic [ADDR_W-1:0]         upd_ghp_index;
  logic                      sp_bit;
  logic [CNT_W-1:0]          lhp_cnt;
  logic [CNT_W-1:0]          ghp_cnt;
  logic [CNT_W-1:0]          upd_lhp_cnt;
  logic [CNT_W-1:0]          upd_ghp_cnt;
  logic signed [STAT_W-1:0]  sp_stat;
  logic signed [STAT_W-1:0]  lhp_stat;
  logic signed [STAT_W-1:0]  ghp_stat;
  logic signed [STAT_W-1:0]  upd_sp_stat;
  logic signed [STAT_W-1:0]  upd_lhp_stat;
  logic signed [STAT_W-1:0]  upd_ghp_stat;
  logic signed [TREND_W-1:0] sp_trend;
  logic signed [TREND_W-1:0] lhp_trend;
  logic signed [TREND_W-1:0] ghp_trend;
  logic signed [TREND_W-1:0] upd_sp_trend;
  logic signed [TREND_W-1:0] upd_lhp_trend;
  logic signed [TREND_W-1:0] upd_ghp_trend;
  logic                      sp_wr_en;
  logic                      lhp_wr_en;
  logic                      ghp_wr_en;
  logic                      sp_stat_wr_en;
  logic                      lhp_stat_wr_en;
  logic                      ghp_stat_wr_en;
  logic                      sp_trend_wr_en;
  logic                      lhp_trend_wr_en;
  logic                      ghp_trend_wr_en;
  logic                      new_sp;
  logic [CNT_W-1:0]          new_lhp_cnt;
  logic [CNT_W-1:0]          new_ghp_cnt;
  logic signed [STAT_W-1:0]  new_sp_stat;
  logic signed [STAT_W-1:0]  new_lhp_stat;
  logic signed [STAT_W-1:0]  new_ghp_stat;
  logic signed [TREND_W-1:0] new_sp_trend;
  logic signed [TREND_W-1:0] new_lhp_trend;
  logic signed [TREND_W-1:0] new_ghp_trend;
  logic                      stat_clr_en;

  predictor_control #(
    .ADDR_W(ADDR_W), .HIST_W(HIST_W), .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_control (
    .clk(clk), .rst_n(rst_n),
    .q_valid(q_valid), .q_ready(q_ready), .q_addr(q_addr),
    .a_valid(a_valid), .a_ready(a_ready), .a_taken(a_taken), .a_src(a_src),
    .o_valid(o_valid), .o_ready(o_ready),
    .sel_sp_guess(sel_sp_guess), .sel_lhp_guess(sel_lhp_guess),
    .sel_ghp_guess(sel_ghp_guess), .sel_taken(sel_taken), .sel_src(sel_src),
    .lhp_index(lhp_index), .ghp_index(ghp_index), .lookup_en(lookup_en),
    .upd_en(upd_en), .upd_addr(upd_addr), .upd_sp_guess(upd_sp_guess),
    .upd_lhp_guess(upd_lhp_guess), .upd_ghp_guess(upd_ghp_guess),
    .upd_lhp_index(upd_lhp_index), .upd_ghp_index(upd_ghp_index)
  );

  prediction_selector #(.STAT_W(STAT_W)) u_selector (
    .clk(clk), .rst_n(rst_n), .lookup_en(lookup_en),
    .sp_bit(sp_bit), .lhp_cnt(lhp_cnt), .ghp_cnt(ghp_cnt),
    .sp_stat(sp_stat), .lhp_stat(lhp_stat), .ghp_stat(ghp_stat),
    .sp_trend(sp_trend), .lhp_trend(lhp_trend), .ghp_trend(ghp_trend),
    .sp_guess(sel_sp_guess), .lhp_guess(sel_lhp_guess), .ghp_guess(sel_ghp_guess),
    .taken(sel_taken), .src(sel_src)
  );

  history_unit #(.ADDR_W(ADDR_W), .HIST_W(HIST_W)) u_history (
    .clk(clk), .rst_n(rst_n), .rd_addr(q_addr),
    .upd_en(upd_en), .upd_addr(upd_addr), .upd_taken(o_taken),
    .lhp_index(lhp_index), .ghp_index(ghp_index)
  );

  prediction_writer #(.STAT_W(STAT_W)) u_writer (
    .clk(clk), .rst_n(rst_n), .upd_en(upd_en),
    .sp_guess(upd_sp_guess), .lhp_guess(upd_lhp_guess), .ghp_guess(upd_ghp_guess),
    .o_taken(o_taken), .lhp_cnt(upd_lhp_cnt), .ghp_cnt(upd_ghp_cnt),
    .sp_stat(upd_sp_stat), .lhp_stat(upd_lhp_stat), .ghp_stat(upd_ghp_stat),
    .sp_trend(upd_sp_trend), .lhp_trend(upd_lhp_trend), .ghp_trend(upd_ghp_trend),
    .sp_wr_en(sp_wr_en), .lhp_wr_en(lhp_wr_en), .ghp_wr_en(ghp_wr_en),
    .sp_stat_wr_en(sp_stat_wr_en), .lhp_stat_wr_en(lhp_stat_wr_en),
    .ghp_stat_wr_en(ghp_stat_wr_en), .sp_trend_wr_en(sp_trend_wr_en),
    .lhp_trend_wr_en(lhp_trend_wr_en), .ghp_trend_wr_en(ghp_trend_wr_en),
    .new_sp(new_sp), .new_lhp_cnt(new_lhp_cnt), .new_ghp_cnt(new_ghp_cnt),
    .new_sp_stat(new_sp_stat), .new_lhp_stat(new_lhp_stat), .new_ghp_stat(new_ghp_stat),
    .new_sp_trend(new_sp_trend), .new_lhp_trend(new_lhp_trend),
    .new_ghp_trend(new_ghp_trend), .stat_clr_en(stat_clr_en)
  );

  // port a serves the lookup, port b the entry being resolved.
  counter_table #(.entry_t(logic), .DEPTH(2**ADDR_W)) u_sp_table (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(sp_bit),
    .rd_addr_b(upd_addr), .rd_data_b(), .wr_en(sp_wr_en), .wr_addr(upd_addr),
    .wr_data(new_sp), .clr_en(1'b0), .clr_addr(upd_addr)
  );

  counter_table #(.entry_t(logic [CNT_W-1:0]), .DEPTH(2**HIST_W)) u_lhp_table (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(lhp_index), .rd_data_a(lhp_cnt),
    .rd_addr_b(upd_lhp_index), .rd_data_b(upd_lhp_cnt), .wr_en(lhp_wr_en),
    .wr_addr(upd_lhp_index), .wr_data(new_lhp_cnt), .clr_en(1'b0), .clr_addr(upd_lhp_index)
  );

  counter_table #(.entry_t(logic [CNT_W-1:0]), .DEPTH(2**ADDR_W)) u_ghp_table (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(ghp_index), .rd_data_a(ghp_cnt),
    .rd_addr_b(upd_ghp_index), .rd_data_b(upd_ghp_cnt), .wr_en(ghp_wr_en),
    .wr_addr(upd_ghp_index), .wr_data(new_ghp_cnt), .clr_en(1'b0), .clr_addr(upd_ghp_index)
  );

  counter_table #(.entry_t(logic signed [STAT_W-1:0]), .DEPTH(2**ADDR_W)) u_sp_stat (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(sp_stat),
    .rd_addr_b(upd_addr), .rd_data_b(upd_sp_stat), .wr_en(sp_stat_wr_en),
    .wr_addr(upd_addr), .wr_data(new_sp_stat), .clr_en(stat_clr_en), .clr_addr(upd_addr)
  );

  counter_table #(.entry_t(logic signed [STAT_W-1:0]), .DEPTH(2**ADDR_W)) u_lhp_stat (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(lhp_stat),
    .rd_addr_b(upd_addr), .rd_data_b(upd_lhp_stat), .wr_en(lhp_stat_wr_en),
    .wr_addr(upd_addr), .wr_data(new_lhp_stat), .clr_en(stat_clr_en), .clr_addr(upd_addr)
  );

  counter_table #(.entry_t(logic signed [STAT_W-1:0]), .DEPTH(2**ADDR_W)) u_ghp_stat (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(ghp_stat),
    .rd_addr_b(upd_addr), .rd_data_b(upd_ghp_stat), .wr_en(ghp_stat_wr_en),
    .wr_addr(upd_addr), .wr_data(new_ghp_stat), .clr_en(stat_clr_en), .clr_addr(upd_addr)
  );

  counter_table #(.entry_t(logic signed [TREND_W-1:0]), .DEPTH(2**ADDR_W)) u_sp_trend (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(sp_trend),
    .rd_addr_b(upd_addr), .rd_data_b(upd_sp_trend), .wr_en(sp_trend_wr_en),
    .wr_addr(upd_addr), .wr_data(new_sp_trend), .clr_en(1'b0), .clr_addr(upd_addr)
  );

  counter_table #(.entry_t(logic signed [TREND_W-1:0]), .DEPTH(2**ADDR_W)) u_lhp_trend (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(lhp_trend),
    .rd_addr_b(upd_addr), .rd_data_b(upd_lhp_trend), .wr_en(lhp_trend_wr_en),
    .wr_addr(upd_addr), .wr_data(new_lhp_trend), .clr_en(1'b0), .clr_addr(upd_addr)
  );

  counter_table #(.entry_t(logic signed [TREND_W-1:0]), .DEPTH(2**ADDR_W)) u_ghp_trend (
    .clk(clk), .rst_n(rst_n), .rd_addr_a(q_addr), .rd_data_a(ghp_trend),
    .rd_addr_b(upd_addr), .rd_data_b(upd_ghp_trend), .wr_en(ghp_trend_wr_en),
    .wr_addr(upd_addr), .wr_data(new_ghp_trend), .clr_en(1'b0), .clr_addr(upd_addr)
  );

endmodule

/* source/counter_table.sv */
`timescale 1ns/1ps

module counter_table #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_a,
  output entry_t                   rd_data_a,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_b,
  output entry_t                   rd_data_b,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  entry_t                   wr_data,
  input  logic                     clr_en,
  input  logic [$clog2(DEPTH)-1:0] clr_addr
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else
    begin
      if (wr_en)
        mem[wr_addr] <= wr_data;
      if (clr_en)
        mem[clr_addr] <= '0;   // a clear overrides a write to the same entry.
    end
  end

  assign rd_data_a = mem[rd_addr_a];
  assign rd_data_b = mem[rd_addr_b];

  // the writer must drop its write whenever it clears the same entry.
  a_clr_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(clr_en && wr_en && (clr_addr == wr_addr)));

endmodule

/* source/history_unit.sv */
`timescale 1ns/1ps

module history_unit #(
  parameter int ADDR_W = bp_pkg::DEF_ADDR_W,
  parameter int HIST_W = bp_pkg::DEF_HIST_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] rd_addr,
  input  logic              upd_en,
  input  logic [ADDR_W-1:0] upd_addr,
  input  logic              upd_taken,
  output logic [HIST_W-1:0] lhp_index,
  output logic [ADDR_W-1:0] ghp_index
);

  logic [HIST_W-1:0] local_hist [2**ADDR_W];
  logic [ADDR_W-1:0] global_hist;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2**ADDR_W; i++)
      begin
        local_hist[i] <= '0;
      end
      global_hist <= '0;
    end
    else if (upd_en)
    begin
      local_hist[upd_addr] <= HIST_W'({local_hist[upd_addr], upd_taken});   // newest in the lsb.
      global_hist          <= ADDR_W'({global_hist, upd_taken});
    end
  end

  assign lhp_index = local_hist[rd_addr];
  assign ghp_index = rd_addr ^ global_hist;   // spreads one history over all addresses.

endmodule

/* source/prediction_selector.sv */
`timescale 1ns/1ps

module prediction_selector #(
  parameter int STAT_W = bp_pkg::DEF_STAT_W
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             lookup_en,
  input  logic                             sp_bit,
  input  logic        [bp_pkg::CNT_W-1:0]   lhp_cnt,
  input  logic        [bp_pkg::CNT_W-1:0]   ghp_cnt,
  input  logic signed [STAT_W-1:0]          sp_stat,
  input  logic signed [STAT_W-1:0]          lhp_stat,
  input  logic signed [STAT_W-1:0]          ghp_stat,
  input  logic signed [bp_pkg::TREND_W-1:0] sp_trend,
  input  logic signed [bp_pkg::TREND_W-1:0] lhp_trend,
  input  logic signed [bp_pkg::TREND_W-1:0] ghp_trend,
  output logic                             sp_guess,
  output logic                             lhp_guess,
  output logic                             ghp_guess,
  output logic                             taken,
  output bp_pkg::pred_src_e                src
);
  import bp_pkg::*;

  logic                      lhp_over_sp;
  logic                      ghp_over_best;
  logic signed [STAT_W-1:0]  best_stat;
  logic signed [TREND_W-1:0] best_trend;
  pred_src_e                 pick;
  logic                      pick_taken;

  // a challenger must be strictly better, so a full tie keeps the earlier predictor.
  assign lhp_over_sp   = (lhp_stat > sp_stat) ||
                         ((lhp_stat == sp_stat) && (lhp_trend > sp_trend));
  assign best_stat     = lhp_over_sp ? lhp_stat : sp_stat;
  assign best_trend    = lhp_over_sp ? lhp_trend : sp_trend;
  assign ghp_over_best = (ghp_stat > best_stat) ||
                         ((ghp_stat == best_stat) && (ghp_trend > best_trend));

  always_comb
  begin
    if (ghp_over_best)
    begin
      pick       = SRC_GHP;
      pick_taken = ghp_cnt[CNT_W-1];
    end
    else if (lhp_over_sp)
    begin
      pick       = SRC_LHP;
      pick_taken = lhp_cnt[CNT_W-1];
    end
    else
    begin
      pick       = SRC_SP;
      pick_taken = sp_bit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sp_guess  <= 1'b0;
      lhp_guess <= 1'b0;
      ghp_guess <= 1'b0;
      taken     <= 1'b0;
      src       <= SRC_SP;
    end
    else if (lookup_en)
    begin
      sp_guess  <= sp_bit;
      lhp_guess <= lhp_cnt[CNT_W-1];
      ghp_guess <= ghp_cnt[CNT_W-1];
      taken     <= pick_taken;
      src       <= pick;
    end
  end

endmodule

/* source/prediction_writer.sv */
`timescale 1ns/1ps

module prediction_writer #(
  parameter int STAT_W = bp_pkg::DEF_STAT_W
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             upd_en,
  input  logic                             sp_guess,
  input  logic                             lhp_guess,
  input  logic                             ghp_guess,
  input  logic                             o_taken,
  input  logic        [bp_pkg::CNT_W-1:0]   lhp_cnt,
  input  logic        [bp_pkg::CNT_W-1:0]   ghp_cnt,
  input  logic signed [STAT_W-1:0]          sp_stat,
  input  logic signed [STAT_W-1:0]          lhp_stat,
  input  logic signed [STAT_W-1:0]          ghp_stat,
  input  logic signed [bp_pkg::TREND_W-1:0] sp_trend,
  input  logic signed [bp_pkg::TREND_W-1:0] lhp_trend,
  input  logic signed [bp_pkg::TREND_W-1:0] ghp_trend,
  output logic                             sp_wr_en,
  output logic                             lhp_wr_en,
  output logic                             ghp_wr_en,
  output logic                             sp_stat_wr_en,
  output logic                             lhp_stat_wr_en,
  output logic                             ghp_stat_wr_en,
  output logic                             sp_trend_wr_en,
  output logic                             lhp_trend_wr_en,
  output logic                             ghp_trend_wr_en,
  output logic                             new_sp,
  output logic        [bp_pkg::CNT_W-1:0]   new_lhp_cnt,
  output logic        [bp_pkg::CNT_W-1:0]   new_ghp_cnt,
  output logic signed [STAT_W-1:0]          new_sp_stat,
  output logic signed [STAT_W-1:0]          new_lhp_stat,
  output logic signed [STAT_W-1:0]          new_ghp_stat,
  output logic signed [bp_pkg::TREND_W-1:0] new_sp_trend,
  output logic signed [bp_pkg::TREND_W-1:0] new_lhp_trend,
  output logic signed [bp_pkg::TREND_W-1:0] new_ghp_trend,
  output logic                             stat_clr_en
);
  import bp_pkg::*;

  localparam logic signed [STAT_W-1:0]  STAT_MAX  = {1'b0, {(STAT_W-1){1'b1}}};
  localparam logic signed [STAT_W-1:0]  STAT_MIN  = {1'b1, {(STAT_W-1){1'b0}}};
  localparam logic signed [TREND_W-1:0] TREND_MAX = 3;
  localparam logic signed [TREND_W-1:0] TREND_MIN = -3;

  logic       sp_fail;
  logic       lhp_fail;
  logic       ghp_fail;
  logic [2:0] stat_of;   // sp in bit 2, lhp in bit 1, ghp in bit 0.

  function automatic logic [CNT_W-1:0] cnt_step(input logic [CNT_W-1:0] cnt, input logic up);
    if (up)
      return (&cnt) ? cnt : cnt + 1'b1;
    return (|cnt) ? cnt - 1'b1 : cnt;
  endfunction

  function automatic logic signed [TREND_W-1:0] trend_step(
    input logic signed [TREND_W-1:0] trend,
    input logic                      fail
  );
    if (fail)
      return (trend <= TREND_MIN) ? trend : trend - 1'b1;
    return (trend >= TREND_MAX) ? trend : trend + 1'b1;
  endfunction

  assign sp_fail  = sp_guess != o_taken;   // judged on the guess given at answer time.
  assign lhp_fail = lhp_guess != o_taken;
  assign ghp_fail = ghp_guess != o_taken;

  assign sp_wr_en  = upd_en;
  assign lhp_wr_en = upd_en;
  assign ghp_wr_en = upd_en;
  assign new_sp      = o_taken;
  assign new_lhp_cnt = cnt_step(lhp_cnt, o_taken);
  assign new_ghp_cnt = cnt_step(ghp_cnt, o_taken);

  assign sp_trend_wr_en  = upd_en;
  assign lhp_trend_wr_en = upd_en;
  assign ghp_trend_wr_en = upd_en;
  assign new_sp_trend  = trend_step(sp_trend, sp_fail);
  assign new_lhp_trend = trend_step(lhp_trend, lhp_fail);
  assign new_ghp_trend = trend_step(ghp_trend, ghp_fail);

  assign new_sp_stat  = sp_fail  ? sp_stat - 1'b1  : sp_stat + 1'b1;
  assign new_lhp_stat = lhp_fail ? lhp_stat - 1'b1 : lhp_stat + 1'b1;
  assign new_ghp_stat = ghp_fail ? ghp_stat - 1'b1 : ghp_stat + 1'b1;

  assign stat_of[2] = sp_fail  ? (sp_stat == STAT_MIN)  : (sp_stat == STAT_MAX);
  assign stat_of[1] = lhp_fail ? (lhp_stat == STAT_MIN) : (lhp_stat == STAT_MAX);
  assign stat_of[0] = ghp_fail ? (ghp_stat == STAT_MIN) : (ghp_stat == STAT_MAX);

  // one overflow restarts all three statistics of the address from zero.
  assign stat_clr_en    = upd_en && (|stat_of);
  assign sp_stat_wr_en  = upd_en && !(|stat_of);
  assign lhp_stat_wr_en = upd_en && !(|stat_of);
  assign ghp_stat_wr_en = upd_en && !(|stat_of);

  a_clr_blocks_stat_wr: assert property (@(posedge clk) disable iff (!rst_n)
    stat_clr_en |-> !(sp_stat_wr_en || lhp_stat_wr_en || ghp_stat_wr_en));

endmodule

/* source/predictor_control.sv */
`timescale 1ns/1ps

module predictor_control #(
  parameter int ADDR_W      = bp_pkg::DEF_ADDR_W,
  parameter int HIST_W      = bp_pkg::DEF_HIST_W,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              q_valid,
  output logic              q_ready,
  input  logic [ADDR_W-1:0] q_addr,
  output logic              a_valid,
  input  logic              a_ready,
  output logic              a_taken,
  output bp_pkg::pred_src_e a_src,
  input  logic              o_valid,
  output logic              o_ready,
  input  logic              sel_sp_guess,
  input  logic              sel_lhp_guess,
  input  logic              sel_ghp_guess,
  input  logic              sel_taken,
  input  bp_pkg::pred_src_e sel_src,
  input  logic [HIST_W-1:0] lhp_index,
  input  logic [ADDR_W-1:0] ghp_index,
  output logic              lookup_en,
  output logic              upd_en,
  output logic [ADDR_W-1:0] upd_addr,
  output logic              upd_sp_guess,
  output logic              upd_lhp_guess,
  output logic              upd_ghp_guess,
  output logic [HIST_W-1:0] upd_lhp_index,
  output logic [ADDR_W-1:0] upd_ghp_index
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int LVL_W = $clog2(QUEUE_DEPTH + 1);

  logic              push;
  logic              pop;
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [LVL_W-1:0]  level;
  logic [ADDR_W-1:0] ans_addr;
  logic [HIST_W-1:0] ans_lhp_index;
  logic [ADDR_W-1:0] ans_ghp_index;
  logic [ADDR_W-1:0] fifo_addr    [QUEUE_DEPTH];
  logic [2:0]        fifo_guess   [QUEUE_DEPTH];   // {sp, lhp, ghp}.
  logic [HIST_W-1:0] fifo_lhp_idx [QUEUE_DEPTH];
  logic [ADDR_W-1:0] fifo_ghp_idx [QUEUE_DEPTH];

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = a_valid && a_ready;
  assign pop  = o_valid && o_ready;

  // the held answer already owns a queue slot, so it counts as outstanding.
  assign q_ready   = (!a_valid || a_ready) && ((int'(level) + int'(a_valid)) < QUEUE_DEPTH);
  assign lookup_en = q_valid && q_ready;
  assign o_ready   = (level != '0);
  assign upd_en    = pop;
  assign a_taken   = sel_taken;
  assign a_src     = sel_src;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      a_valid <= 1'b0;
    else if (lookup_en)
      a_valid <= 1'b1;
    else if (a_ready)
      a_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (lookup_en)
    begin
      ans_addr      <= q_addr;
      ans_lhp_index <= lhp_index;
      ans_ghp_index <= ghp_index;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop)
        level <= level + 1'b1;
      else if (pop && !push)
        level <= level - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      fifo_addr[wr_ptr]    <= ans_addr;
      fifo_guess[wr_ptr]   <= {sel_sp_guess, sel_lhp_guess, sel_ghp_guess};
      fifo_lhp_idx[wr_ptr] <= ans_lhp_index;
      fifo_ghp_idx[wr_ptr] <= ans_ghp_index;
    end
  end

  assign upd_addr      = fifo_addr[rd_ptr];
  assign upd_sp_guess  = fifo_guess[rd_ptr][2];
  assign upd_lhp_guess = fifo_guess[rd_ptr][1];
  assign upd_ghp_guess = fifo_guess[rd_ptr][0];
  assign upd_lhp_index = fifo_lhp_idx[rd_ptr];
  assign upd_ghp_index = fifo_ghp_idx[rd_ptr];

  // q_ready reserved the slot when the query was taken, cycles before the push.
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (int'(level) < QUEUE_DEPTH));
  // equal pointers mean an empty queue unless the level says it is full.
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> ((rd_ptr != wr_ptr) || (int'(level) == QUEUE_DEPTH)));

endmodule

/* tb/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

localparam int N_ADDR   = 2**ADDR_W;
localparam int N_LHP    = 2**HIST_W;
localparam int STAT_MAX = 2**(STAT_W-1) - 1;
localparam int STAT_MIN = -(2**(STAT_W-1));

bit        m_sp    [N_ADDR];
int        m_lhp   [N_LHP];     // pattern counters held as 0 to 3.
int        m_ghp   [N_ADDR];
int        m_stat  [3][N_ADDR]; // index 0 is sp, 1 is lhp, 2 is ghp.
int        m_trend [3][N_ADDR];
int        m_lhist [N_ADDR];
int        m_ghist;
bit        exp_taken_q [$];
pred_src_e exp_src_q   [$];
int        snap_addr   [$];     // lookups not yet resolved in age order.
bit [2:0]  snap_guess  [$];
int        snap_li     [$];
int        snap_gi     [$];

function automatic int sat_cnt(input int cnt, input bit up);
  if (up)
    return (cnt == 3) ? 3 : cnt + 1;
  return (cnt == 0) ? 0 : cnt - 1;
endfunction

task automatic model_lookup(input int addr);
  int       li;
  int       gi;
  int       best;
  bit [2:0] g;
  li = m_lhist[addr];
  gi = addr ^ m_ghist;
  g  = {m_sp[addr], m_lhp[li] >= 2, m_ghp[gi] >= 2};
  best = 0;
  for (int i = 1; i < 3; i++)
  begin
    if ((m_stat[i][addr] > m_stat[best][addr]) ||
        ((m_stat[i][addr] == m_stat[best][addr]) && (m_trend[i][addr] > m_trend[best][addr])))
      best = i;
  end
  exp_taken_q.push_back(g[2-best]);
  exp_src_q.push_back(pred_src_e'(best));
  snap_addr.push_back(addr);
  snap_guess.push_back(g);
  snap_li.push_back(li);
  snap_gi.push_back(gi);
endtask

task automatic model_update(input bit t);
  int       addr;
  int       li;
  int       gi;
  int       ns [3];
  bit [2:0] g;
  bit       fl;
  bit       ovf;
  addr = snap_addr.pop_front();
  g    = snap_guess.pop_front();
  li   = snap_li.pop_front();
  gi   = snap_gi.pop_front();
  m_sp[addr] = t;
  m_lhp[li]  = sat_cnt(m_lhp[li], t);
  m_ghp[gi]  = sat_cnt(m_ghp[gi], t);
  ovf = 1'b0;
  for (int i = 0; i < 3; i++)
  begin
    fl    = (g[2-i] != t);
    ns[i] = m_stat[i][addr] + (fl ? -1 : 1);
    if ((ns[i] > STAT_MAX) || (ns[i] < STAT_MIN))
      ovf = 1'b1;
    if (fl)
      m_trend[i][addr] = (m_trend[i][addr] <= -3) ? -3 : m_trend[i][addr] - 1;
    else
      m_trend[i][addr] = (m_trend[i][addr] >= 3) ? 3 : m_trend[i][addr] + 1;
  end
  for (int i = 0; i < 3; i++)
    m_stat[i][addr] = ovf ? 0 : ns[i];
  m_lhist[addr] = ((m_lhist[addr] << 1) | t) % N_LHP;
  m_ghist       = ((m_ghist << 1) | t) % N_ADDR;
endtask

`endif

/* tb/tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor;
  import bp_pkg::*;

  localparam int ADDR_W      = 3;
  localparam int HIST_W      = 2;
  localparam int STAT_W      = 5;
  localparam int QUEUE_DEPTH = 4;

  logic              clk;
  logic              rst_n;
  logic              q_valid;
  logic              q_ready;
  logic [ADDR_W-1:0] q_addr;
  logic              a_valid;
  logic              a_ready;
  logic              a_taken;
  pred_src_e         a_src;
  logic              o_valid;
  logic              o_ready;
  logic              o_taken;

  logic [15:0] lfsr = 16'd46;
  string       test_name = "reset";
  bit          q_fire;
  bit          a_fire;
  bit          o_fire;
  int          ans_cnt;        // answered branches still waiting for an outcome.
  int          cnt_now;
  int          answers_seen;
  bit          first_now = 1'b1;
  bit          exp_taken;
  pred_src_e   exp_src = SRC_SP;
  bit          alt [2**ADDR_W];

  `include "bp_ref_model.svh"

  branch_predictor #(
    .ADDR_W(ADDR_W), .HIST_W(HIST_W), .STAT_W(STAT_W), .QUEUE_DEPTH(QUEUE_DEPTH)
  ) UUT (
    .clk(clk), .rst_n(rst_n),
    .q_valid(q_valid), .q_ready(q_ready), .q_addr(q_addr),
    .a_valid(a_valid), .a_ready(a_ready), .a_taken(a_taken), .a_src(a_src),
    .o_valid(o_valid), .o_ready(o_ready), .o_taken(o_taken)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // galois lfsr stepped once for every bit taken.
  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++)
    begin
      r    = (r << 1) | lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic bit pick_outcome(input int addr);
    if (addr == 0)
      return 1'b0;
    if (addr == 1)
      return 1'b1;
    if (addr < 4)
    begin
      alt[addr] = !alt[addr];   // alternating branches favour the local history.
      return alt[addr];
    end
    return rand_bits(3) < addr;
  endfunction

  task automatic step(input bit q_want, input bit a_want, input bit o_want, input int addr);
    @(negedge clk);
    if (!q_valid || q_fire)
    begin
      q_valid = q_want;
      q_addr  = addr;
    end
    a_ready = a_want;
    if (!o_valid || o_fire)
    begin
      o_valid = o_want;
      o_taken = pick_outcome((snap_addr.size() != 0) ? snap_addr[0] : 0);
    end
    #1;
    cnt_now   = ans_cnt;
    first_now = (answers_seen == 0);
    if (exp_taken_q.size() != 0)
    begin
      exp_taken = exp_taken_q[0];
      exp_src   = exp_src_q[0];
    end
    q_fire = q_valid && q_ready && rst_n;
    a_fire = a_valid && a_ready && rst_n;
    o_fire = o_valid && o_ready && rst_n;
    if (q_fire)
      model_lookup(q_addr);   // the lookup sees the state before this edge's update.
    if (a_fire)
    begin
      void'(exp_taken_q.pop_front());
      void'(exp_src_q.pop_front());
      ans_cnt++;
      answers_seen++;
    end
    if (o_fire)
    begin
      model_update(o_taken);
      ans_cnt--;
    end
  endtask

  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (!a_valid && !o_ready))
    else report_failure("a_valid or o_ready is high right after reset");

  a_first_answer: assert property (@(posedge clk) disable iff (!rst_n)
    (a_valid && first_now) |-> (!a_taken && (a_src == SRC_SP)))
    else report_failure($sformatf("mismatch %s: expected 0/SRC_SP actual %0d/%s",
                                  test_name, a_taken, a_src.name()));

  a_answer_value: assert property (@(posedge clk) disable iff (!rst_n)
    (a_valid && a_ready) |-> ((a_taken == exp_taken) && (a_src == exp_src)))
    else report_failure($sformatf("mismatch %s: expected %0d/%s actual %0d/%s", test_name,
                                  exp_taken, exp_src.name(), a_taken, a_src.name()));

  a_answer_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (a_valid && !a_ready) |=> (a_valid && $stable(a_taken) && $stable(a_src)))
    else report_failure("the answer changed while it was held back");

  a_query_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (a_valid && !a_ready) |-> !q_ready)
    else report_failure("q_ready is high while the answer is held back");

  a_queue_full: assert property (@(posedge clk) disable iff (!rst_n)
    ((cnt_now + int'(a_valid)) >= QUEUE_DEPTH) |-> !q_ready)
    else report_failure("q_ready is high with the queue full");

  a_outcome_ready: assert property (@(posedge clk) disable iff (!rst_n)
    o_ready == (cnt_now != 0))
    else report_failure($sformatf("mismatch %s: expected o_ready %0d actual %0d",
                                  test_name, cnt_now != 0, o_ready));

  initial
  begin
    int guard;
    rst_n   = 1'b0;
    q_valid = 1'b0;
    q_addr  = '0;
    a_ready = 1'b0;
    o_valid = 1'b0;
    o_taken = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 4; i++)
      step(1'b1, i == 3, 1'b0, 3);
    test_name = "random_run";
    for (int i = 0; i < 1500; i++)
      step(rand_bits(2) != 0, rand_bits(2) != 0, rand_bits(2) != 0, rand_bits(3));
    test_name = "stat_overflow";
    for (int i = 0; i < 80; i++)
      step(1'b1, 1'b1, 1'b1, 1);
    test_name = "back_pressure";
    for (int i = 0; i < 6; i++)
      step(1'b1, 1'b0, 1'b0, 5);
    test_name = "queue_full";
    for (int i = 0; i < 12; i++)
      step(1'b1, 1'b1, 1'b0, rand_bits(3));
    test_name = "drain";
    guard = 0;
    while ((snap_addr.size() != 0) || q_valid)
    begin
      step(1'b0, 1'b1, 1'b1, 0);
      guard++;
      if (guard > 200)
        report_failure("timeout while waiting for outstanding branches to resolve");
    end
    step(1'b0, 1'b1, 1'b0, 0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
